/* src/cv32e40x_fetch_pkg.sv */
////////////////////////////////////////
// Instruction fetch package
// Controller states, OBI instruction bus channels and the fetch entry
// handed to decode
////////////////////////////////////////

package cv32e40x_fetch_pkg;

  // Default number of FIFO entries, power of two
  localparam int DEPTH_DEFAULT = 4;

  // Prefetch controller states
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_ISSUE,
    FETCH_BRANCH_PEND
  } fetch_state_e;

  // OBI request channel, driven by the core
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } obi_instr_req_t;

  // OBI response channel, driven by the memory
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_instr_resp_t;

  // One fetched word with the address it was read from
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] instr;
  } fetch_item_t;

endpackage

/* src/cv32e40x_prefetch_controller.sv */
////////////////////////////////////////
// Prefetch controller
// Issues OBI instruction requests, tracks the next fetch address
// and redirects fetching on a branch
////////////////////////////////////////

`timescale 1ns/1ps

module cv32e40x_prefetch_controller #(
  parameter int DEPTH = cv32e40x_fetch_pkg::DEPTH_DEFAULT,
  parameter int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               fetch_enable_i,
  input  logic [31:0]                        boot_addr_i,
  input  logic                               branch_i,
  input  logic [31:0]                        branch_addr_i,
  input  logic                               gnt_i,
  input  logic [CNT_W-1:0]                   fifo_cnt_i,
  input  logic [CNT_W-1:0]                   outstanding_i,
  output cv32e40x_fetch_pkg::obi_instr_req_t obi_req_o,
  output logic                               accept_o,
  output logic                               flush_o
);

  import cv32e40x_fetch_pkg::*;

  localparam logic [CNT_W:0] MAX_USED = (CNT_W + 1)'(DEPTH);

  fetch_state_e   state_q;
  fetch_state_e   state_d;
  logic [31:0]    addr_q;
  logic [31:0]    addr_d;
  logic [31:0]    pend_addr_q;
  logic [31:0]    pend_addr_d;
  logic [CNT_W:0] used_cnt;
  logic           space;
  logic           req;
  logic           flush;

  // Entries already buffered plus responses still on their way
  assign used_cnt = {1'b0, fifo_cnt_i} + {1'b0, outstanding_i};
  assign space    = (used_cnt < MAX_USED);

  always_comb begin
    state_d     = state_q;
    addr_d      = addr_q;
    pend_addr_d = pend_addr_q;
    req         = 1'b0;
    flush       = 1'b0;
    case (state_q)
      FETCH_IDLE: begin
        if (branch_i) begin
          addr_d = branch_addr_i;
          flush  = 1'b1;
        end
        if (fetch_enable_i) begin
          state_d = FETCH_ISSUE;
        end
      end
      FETCH_ISSUE: begin
        // The space rule cannot fall while a request waits for gnt
        req = space;
        if (req && gnt_i) begin
          addr_d = addr_q + 32'd4;
        end
        if (branch_i) begin
          flush = 1'b1;
          if (req && !gnt_i) begin
            // Old request must stay on the bus until granted
            pend_addr_d = branch_addr_i;
            state_d     = FETCH_BRANCH_PEND;
          end else begin
            addr_d = branch_addr_i;
          end
        end else if (!fetch_enable_i && !(req && !gnt_i)) begin
          state_d = FETCH_IDLE;
        end
      end
      FETCH_BRANCH_PEND: begin
        req = 1'b1;
        if (branch_i) begin
          pend_addr_d = branch_addr_i;
        end
        // Flushing again on gnt marks the stale request for discard
        flush = branch_i || gnt_i;
        if (gnt_i) begin
          addr_d  = branch_i ? branch_addr_i : pend_addr_q;
          state_d = FETCH_ISSUE;
        end
      end
      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= FETCH_IDLE;
      addr_q  <= boot_addr_i;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    pend_addr_q <= pend_addr_d;
  end

  assign obi_req_o.req  = req;
  assign obi_req_o.addr = addr_q;
  assign accept_o       = req && gnt_i;
  assign flush_o        = flush;

endmodule

/* src/cv32e40x_outstanding_cnt.sv */
////////////////////////////////////////
// Outstanding transaction counter
// Counts granted requests awaiting rvalid and the stale
// responses to drop after a flush
////////////////////////////////////////

`timescale 1ns/1ps

module cv32e40x_outstanding_cnt #(
  parameter int DEPTH = cv32e40x_fetch_pkg::DEPTH_DEFAULT,
  parameter int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             accept_i,
  input  logic             rvalid_i,
  input  logic             flush_i,
  output logic [CNT_W-1:0] outstanding_o,
  output logic             drop_o
);

  logic [CNT_W-1:0] outstanding_q;
  logic [CNT_W-1:0] outstanding_d;
  logic [CNT_W-1:0] discard_q;
  logic [CNT_W-1:0] discard_d;

  assign drop_o = rvalid_i && (discard_q != '0);

  always_comb begin
    outstanding_d = outstanding_q;
    if (accept_i && !rvalid_i) begin
      outstanding_d = outstanding_q + CNT_W'(1);
    end else if (!accept_i && rvalid_i) begin
      outstanding_d = outstanding_q - CNT_W'(1);
    end
  end

  // Every request still in flight after a flush belongs to the old stream
  always_comb begin
    discard_d = discard_q;
    if (flush_i) begin
      discard_d = outstanding_d;
    end else if (drop_o) begin
      discard_d = discard_q - CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= '0;
      discard_q     <= '0;
    end else begin
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
    end
  end

  assign outstanding_o = outstanding_q;

endmodule

/* src/cv32e40x_fetch_fifo.sv */
////////////////////////////////////////
// Fetch FIFO
// Circular buffer of fetched words and their addresses, with flush
////////////////////////////////////////

`timescale 1ns/1ps

module cv32e40x_fetch_fifo #(
  parameter int DEPTH = cv32e40x_fetch_pkg::DEPTH_DEFAULT,
  parameter int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            push_i,
  input  cv32e40x_fetch_pkg::fetch_item_t item_i,
  input  logic                            pop_i,
  input  logic                            flush_i,
  output logic                            valid_o,
  output cv32e40x_fetch_pkg::fetch_item_t item_o,
  output logic [CNT_W-1:0]                cnt_o
);

  import cv32e40x_fetch_pkg::*;

  // DEPTH is a power of two so the pointers wrap on their own
  localparam int PTR_W = $clog2(DEPTH);

  fetch_item_t      mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + CNT_W'(1);
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  // Only the pointers decide which entries are live
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= item_i;
    end
  end

  assign valid_o = (cnt_q != '0);
  assign item_o  = mem_q[rd_ptr_q];
  assign cnt_o   = cnt_q;

endmodule

/* src/cv32e40x_fetch_wrapper.sv */
////////////////////////////////////////
// Instruction fetch top level
// Prefetch controller, counter and FIFO behind flat OBI ports
////////////////////////////////////////

`timescale 1ns/1ps

module cv32e40x_fetch_wrapper #(
  parameter int DEPTH = cv32e40x_fetch_pkg::DEPTH_DEFAULT
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            fetch_enable_i,
  input  logic [31:0]                     boot_addr_i,
  input  logic                            branch_i,
  input  logic [31:0]                     branch_addr_i,
  // OBI instruction bus
  output logic                            instr_req_o,
  output logic [31:0]                     instr_addr_o,
  input  logic                            instr_gnt_i,
  input  logic                            instr_rvalid_i,
  input  logic [31:0]                     instr_rdata_i,
  // Decode side
  output logic                            fetch_valid_o,
  output cv32e40x_fetch_pkg::fetch_item_t fetch_o,
  input  logic                            fetch_ready_i
);

  import cv32e40x_fetch_pkg::*;

  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int PTR_W = $clog2(DEPTH);

  obi_instr_req_t   instr_req;
  obi_instr_resp_t  instr_resp;
  fetch_item_t      push_item;
  logic             accept;
  logic             flush;
  logic             drop;
  logic             push;
  logic [CNT_W-1:0] outstanding;
  logic [CNT_W-1:0] fifo_cnt;
  logic [31:0]      aq_mem_q [DEPTH];
  logic [PTR_W-1:0] aq_wr_ptr_q;
  logic [PTR_W-1:0] aq_rd_ptr_q;

  assign instr_req_o       = instr_req.req;
  assign instr_addr_o      = instr_req.addr;
  assign instr_resp.gnt    = instr_gnt_i;
  assign instr_resp.rvalid = instr_rvalid_i;
  assign instr_resp.rdata  = instr_rdata_i;

  cv32e40x_prefetch_controller #(
    .DEPTH ( DEPTH )
  ) i_prefetch_controller (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .branch_i       ( branch_i       ),
    .branch_addr_i  ( branch_addr_i  ),
    .gnt_i          ( instr_resp.gnt ),
    .fifo_cnt_i     ( fifo_cnt       ),
    .outstanding_i  ( outstanding    ),
    .obi_req_o      ( instr_req      ),
    .accept_o       ( accept         ),
    .flush_o        ( flush          )
  );

  cv32e40x_outstanding_cnt #(
    .DEPTH ( DEPTH )
  ) i_outstanding_cnt (
    .clk_i         ( clk_i             ),
    .reset_i       ( reset_i           ),
    .accept_i      ( accept            ),
    .rvalid_i      ( instr_resp.rvalid ),
    .flush_i       ( flush             ),
    .outstanding_o ( outstanding       ),
    .drop_o        ( drop              )
  );

  // Addresses of accepted requests whose responses will be kept
  always_ff @(posedge clk_i) begin
    if (reset_i || flush) begin
      aq_wr_ptr_q <= '0;
      aq_rd_ptr_q <= '0;
    end else begin
      if (accept) begin
        aq_wr_ptr_q <= aq_wr_ptr_q + PTR_W'(1);
      end
      if (push) begin
        aq_rd_ptr_q <= aq_rd_ptr_q + PTR_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      aq_mem_q[aq_wr_ptr_q] <= instr_req.addr;
    end
  end

  assign push            = instr_resp.rvalid && !drop;
  assign push_item.addr  = aq_mem_q[aq_rd_ptr_q];
  assign push_item.instr = instr_resp.rdata;

  cv32e40x_fetch_fifo #(
    .DEPTH ( DEPTH )
  ) i_fetch_fifo (
    .clk_i   ( clk_i                          ),
    .reset_i ( reset_i                        ),
    .push_i  ( push                           ),
    .item_i  ( push_item                      ),
    .pop_i   ( fetch_valid_o && fetch_ready_i ),
    .flush_i ( flush                          ),
    .valid_o ( fetch_valid_o                  ),
    .item_o  ( fetch_o                        ),
    .cnt_o   ( fifo_cnt                       )
  );

endmodule

/* bench/fetch_checker.sv */
////////////////////////////////////////
// Fetch stream checker
// Watches the OBI and decode ports and checks the fetched stream
////////////////////////////////////////

`timescale 1ns/1ps

module fetch_checker #(
  parameter int DEPTH = cv32e40x_fetch_pkg::DEPTH_DEFAULT
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            fetch_enable_i,
  input  logic [31:0]                     boot_addr_i,
  input  logic                            branch_i,
  input  logic [31:0]                     branch_addr_i,
  input  logic                            instr_req_i,
  input  logic [31:0]                     instr_addr_i,
  input  logic                            instr_gnt_i,
  input  logic                            instr_rvalid_i,
  input  logic                            fetch_valid_i,
  input  cv32e40x_fetch_pkg::fetch_item_t fetch_i,
  input  logic                            fetch_ready_i,
  input  int                              test_id_i,
  input  logic                            test_end_i,
  output int                              errors_o
);

  logic [31:0] exp_addr;
  logic [31:0] held_addr;
  logic        held_req;
  logic        enabled_seen;
  int          outstanding;
  int          run_id;
  int          run_items;
  int          run_errors;
  int          tests_passed;
  int          tests_failed;

  task automatic report_error(input string msg);
    $display("FAIL @%0t: %s", $time, msg);
    run_errors++;
    errors_o++;
  endtask

  task automatic close_test();
    if (run_errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %0d done: %0d items, %0d errors", run_id, run_items, run_errors);
    run_items  = 0;
    run_errors = 0;
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      exp_addr     = boot_addr_i;
      held_addr    = '0;
      held_req     = 1'b0;
      enabled_seen = 1'b0;
      outstanding  = 0;
      run_id       = 0;
      run_items    = 0;
      run_errors   = 0;
      tests_passed = 0;
      tests_failed = 0;
      errors_o     = 0;
    end else begin
      // Both sides stay quiet until fetching is enabled
      if (fetch_enable_i) begin
        enabled_seen = 1'b1;
      end else if (!enabled_seen && (instr_req_i || fetch_valid_i)) begin
        report_error("instr_req_o or fetch_valid_o high while fetch_enable_i is low");
      end
      // Ungranted request keeps req and addr
      if (held_req && !(instr_req_i && instr_addr_i == held_addr)) begin
        report_error($sformatf("request at %h changed before gnt", held_addr));
      end
      held_req  = instr_req_i && !instr_gnt_i;
      held_addr = instr_addr_i;
      if (instr_req_i && instr_gnt_i) begin
        outstanding++;
      end
      if (instr_rvalid_i) begin
        outstanding--;
      end
      if (outstanding > DEPTH) begin
        report_error($sformatf("%0d requests outstanding, limit %0d", outstanding, DEPTH));
      end
      if (branch_i) begin
        close_test();
        run_id   = test_id_i;
        exp_addr = branch_addr_i;
      end else if (fetch_valid_i && fetch_ready_i) begin
        run_items++;
        if (fetch_i.addr != exp_addr) begin
          report_error($sformatf("item address %h, expected %h", fetch_i.addr, exp_addr));
        end
        if (fetch_i.instr != ~fetch_i.addr) begin
          report_error($sformatf("item at %h holds %h", fetch_i.addr, fetch_i.instr));
        end
        // Fetch goes on word by word from the boot or branch address
        exp_addr = exp_addr + 32'd4;
      end
      if (test_end_i) begin
        close_test();
        $display("Tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, errors_o);
      end
    end
  end

endmodule

/* bench/tb_fetch_wrapper.sv */
////////////////////////////////////////
// Fetch wrapper testbench
// Trace driven consumer with a random latency OBI memory
////////////////////////////////////////

`timescale 1ns/1ps

module tb_fetch_wrapper;

  import cv32e40x_fetch_pkg::*;

  localparam int DEPTH     = DEPTH_DEFAULT;
  localparam int MAX_TESTS = 32;

  logic        clk_i          = 1'b0;
  logic        reset_i;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        branch_i;
  logic [31:0] branch_addr_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i    = 1'b0;
  logic        instr_rvalid_i = 1'b0;
  logic [31:0] instr_rdata_i  = '0;
  logic        fetch_valid_o;
  fetch_item_t fetch_o;
  logic        fetch_ready_i;
  int          test_id;
  logic        test_end;
  int          check_errors;

  // One entry per trace line
  logic [31:0] test_addr  [MAX_TESTS];
  int          test_cnt   [MAX_TESTS];
  int          test_ready [MAX_TESTS];
  int          test_gnt   [MAX_TESTS];
  int          num_tests;
  int          cycle_limit = 0;
  int          cycle_cnt   = 0;

  // Accepted requests waiting for their response, in grant order
  logic [31:0] rsp_addr_q [$];
  int          rsp_due_q  [$];
  int          last_due;
  int          gnt_hold;

  always #20 clk_i = ~clk_i;

  cv32e40x_fetch_wrapper #(
    .DEPTH ( DEPTH )
  ) i_cv32e40x_fetch_wrapper (.*);

  fetch_checker #(
    .DEPTH ( DEPTH )
  ) i_fetch_checker (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .branch_i       ( branch_i       ),
    .branch_addr_i  ( branch_addr_i  ),
    .instr_req_i    ( instr_req_o    ),
    .instr_addr_i   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .fetch_valid_i  ( fetch_valid_o  ),
    .fetch_i        ( fetch_o        ),
    .fetch_ready_i  ( fetch_ready_i  ),
    .test_id_i      ( test_id        ),
    .test_end_i     ( test_end       ),
    .errors_o       ( check_errors   )
  );

  // Run limit from the length of the trace
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout, the trace did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // OBI memory with random gnt and in-order responses of inverted address
  always @(posedge clk_i) begin
    int due;
    if (reset_i) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      rsp_addr_q.delete();
      rsp_due_q.delete();
      last_due = 0;
      gnt_hold = 0;
    end else begin
      if (instr_req_o && instr_gnt_i) begin
        due = cycle_cnt + int'($urandom_range(3, 1));
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_addr_q.push_back(instr_addr_o);
        rsp_due_q.push_back(due);
      end
      // Stall gnt right after a branch so a pending request has to wait
      if (branch_i) begin
        gnt_hold = 3;
      end else if (gnt_hold > 0) begin
        gnt_hold--;
      end
      instr_gnt_i <= (gnt_hold == 0) && ($urandom_range(99) < test_gnt[test_id]);
      if (rsp_due_q.size() > 0 && rsp_due_q[0] == cycle_cnt + 1) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= ~rsp_addr_q.pop_front();
        void'(rsp_due_q.pop_front());
      end else begin
        instr_rvalid_i <= 1'b0;
      end
    end
  end

  initial begin
    int               fd;
    int               code;
    int               total;
    int               taken;
    logic [8*16-1:0]  tok;
    logic [8*200-1:0] rest;
    void'($urandom(64632));
    reset_i        <= 1'b1;
    fetch_enable_i <= 1'b0;
    boot_addr_i    <= '0;
    branch_i       <= 1'b0;
    branch_addr_i  <= '0;
    fetch_ready_i  <= 1'b0;
    test_id        <= 0;
    test_end       <= 1'b0;
    num_tests      = 0;
    total          = 0;
    fd = $fopen("bench/fetch_trace.txt", "r");
    if (fd != 0) begin
      code = $fscanf(fd, "%s", tok);
      while (code == 1 && num_tests < MAX_TESTS) begin
        // Lines opening with # describe the columns
        if (tok[7:0] == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %d %d %d", test_addr[num_tests], test_cnt[num_tests],
                         test_ready[num_tests], test_gnt[num_tests]);
          total += test_cnt[num_tests];
          num_tests++;
        end
        code = $fscanf(fd, "%s", tok);
      end
      $fclose(fd);
    end
    if (num_tests == 0) begin
      $display("No tests could be read from bench/fetch_trace.txt");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      cycle_limit = total * 20 + 200;
      // First line's address is where fetching boots
      boot_addr_i <= test_addr[0];
      repeat (10) @(posedge clk_i);
      reset_i <= 1'b0;
      // Fetching stays off for a while after reset
      repeat (16) @(posedge clk_i);
      fetch_enable_i <= 1'b1;
      for (int t = 0; t < num_tests; t++) begin
        test_id <= t;
        if (t > 0) begin
          branch_i      <= 1'b1;
          branch_addr_i <= test_addr[t];
          @(posedge clk_i);
          branch_i <= 1'b0;
        end
        taken = 0;
        while (taken < test_cnt[t]) begin
          fetch_ready_i <= ($urandom_range(99) < test_ready[t]);
          @(posedge clk_i);
          if (fetch_valid_o && fetch_ready_i) begin
            taken++;
          end
        end
        fetch_ready_i <= 1'b0;
      end
      test_end <= 1'b1;
      @(posedge clk_i);
      test_end <= 1'b0;
      @(negedge clk_i);
      if (check_errors == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

endmodule

/* bench/fetch_trace.txt */
# test id, branch address (hex), instruction count, ready duty %, gnt duty %
# the first line has no branch and its address is the boot address
0 00001000 24 100 100
1 00002000 20  50  60
2 00003ffc 16  20  80
3 00000400 12 100  25
4 80000000 30  10  50
5 00001000 18  70  15
6 0000fff0 10  40 100
7 00004444 25  90  30
8 00000000  8  60  20
9 7ffffff8 14  35  70

/* all.f */
src/cv32e40x_fetch_pkg.sv
src/cv32e40x_prefetch_controller.sv
src/cv32e40x_outstanding_cnt.sv
src/cv32e40x_fetch_fifo.sv
src/cv32e40x_fetch_wrapper.sv
bench/fetch_checker.sv
bench/tb_fetch_wrapper.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch wrapper testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_fetch_wrapper -o tb_fetch_wrapper
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_fetch_wrapper)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation run failed with status $status"
  exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
